/* Bender.yml */
package:
  name: cpu16

sources:
  - isaPkg.sv
  - corePkg.sv
  - stageIfs.sv
  - aluUnit.sv
  - regFile.sv
  - fetchStage.sv
  - decodeStage.sv
  - executeStage.sv
  - memStage.sv
  - cpuTop.sv
  - target: test
    files:
      - cpuTb.sv

/* aluUnit.sv */
// ALU: add, subtract, logic, pass-B, signed multiply and divide with R15 side result
`timescale 1ns/1ps

module aluUnit import isaPkg::*, corePkg::*; (
	input logic [wordWidth-1:0] opA,
	input logic [wordWidth-1:0] opB,
	input logic [aluOpWidth-1:0] aluOp,
	output logic [wordWidth-1:0] result,
	output logic [wordWidth-1:0] r15Result
);

	logic signed [2*wordWidth-1:0] product;
	logic signed [wordWidth-1:0] quotient;
	logic signed [wordWidth-1:0] remainder;

	assign product = $signed(opA) * $signed(opB);
	assign quotient = $signed(opA) / $signed(opB);	// Truncates toward zero
	assign remainder = $signed(opA) % $signed(opB);	// Sign follows dividend

	always_comb
	begin
		result = '0;
		r15Result = '0;
		case (aluOp)
			aluAdd: result = opA + opB;
			aluSub: result = opA - opB;
			aluAnd: result = opA & opB;
			aluOr: result = opA | opB;
			aluPassB: result = opB;
			aluMul:
			begin
				result = product[wordWidth-1:0];
				r15Result = product[2*wordWidth-1:wordWidth];	// High half
			end
			aluDiv:
			begin
				result = (opB == '0) ? '1 : quotient;	// All ones on divide by zero
				r15Result = (opB == '0) ? opA : remainder;
			end
			default: result = '0;
		endcase
	end

endmodule

/* corePkg.sv */
// Microarchitecture package: ALU operation codes, forwarding selects and branch kinds
package corePkg;

	// Internal ALU operations
	localparam int aluOpWidth = 3;
	localparam logic [aluOpWidth-1:0] aluAdd = 3'd0;
	localparam logic [aluOpWidth-1:0] aluSub = 3'd1;
	localparam logic [aluOpWidth-1:0] aluAnd = 3'd2;
	localparam logic [aluOpWidth-1:0] aluOr = 3'd3;
	localparam logic [aluOpWidth-1:0] aluMul = 3'd4;
	localparam logic [aluOpWidth-1:0] aluDiv = 3'd5;
	localparam logic [aluOpWidth-1:0] aluPassB = 3'd6;	// MOV

	// Operand source in execute
	localparam int fwdWidth = 2;
	localparam logic [fwdWidth-1:0] fwdNone = 2'd0;	// Value read in decode
	localparam logic [fwdWidth-1:0] fwdMem = 2'd1;
	localparam logic [fwdWidth-1:0] fwdWb = 2'd2;

	// Branch condition, ra against zero
	localparam int branchWidth = 2;
	localparam logic [branchWidth-1:0] brNone = 2'd0;
	localparam logic [branchWidth-1:0] brGt = 2'd1;
	localparam logic [branchWidth-1:0] brLt = 2'd2;
	localparam logic [branchWidth-1:0] brEq = 2'd3;

endpackage

/* cpuPatterns.txt */
// Records k_aaaa_dddd in hex: kind, 16-bit address, 16-bit data
// Kind 1 program word at byte address, 2 initial data word, 3 expected store in order
// Chains with forwarding, one no-op, first stores
1_0000_9105 1_0002_9203 1_0004_F120 1_0006_F210
1_0008_F121 1_000A_F112 1_000C_F317 1_000E_9410
1_0010_9D20 1_0012_D140 1_0014_D241 1_0016_D342
// ANDi and ORi
1_0018_F517 1_001A_855A 1_001C_95A1 1_001E_D543
1_0020_F617 1_0022_9602 1_0024_D644
// MUL, DIV, divide by zero, R15 stores
1_0026_F717 1_0028_98C8 1_002A_F784 1_002C_D745
1_002E_DF46 1_0030_9B07 1_0032_F7B5 1_0034_D747
1_0036_DFD8 1_0038_9C2F 1_003A_FC05 1_003C_DCD9
1_003E_DFDA
// Loads used at once, base plus signed offset
1_0040_9E34 1_0042_C1EC 1_0044_F110 1_0046_D1DB
1_0048_C2E3 1_004A_D2DC 1_004C_C3E0 1_004E_C532
1_0050_D5DD
// Branches taken and not taken, shadow words never land
1_0052_4102 1_0054_0000 1_0056_D1DE 1_0058_4602
1_005A_D6DE 1_005C_5602 1_005E_D6DF 1_0060_D2DF
1_0062_5102 1_0064_D1DF 1_0066_F221 1_0068_6202
1_006A_D6D0 1_006C_0000 1_006E_6102 1_0070_D2D0
// Halt, the stores after it never issue
1_0072_0000 1_0074_D1D1 1_0076_D6D2
// Initial data
2_0030_1234 2_0034_0010 2_0037_0F0F
// Expected stores
3_0010_FFFD 3_0011_000B 3_0012_FFFD 3_0013_00F9
3_0014_FFFF 3_0015_FDA8 3_0016_FFFF 3_0017_FFAB
3_0018_FFFB 3_0019_FFFF 3_001A_002F 3_001B_2468
3_001C_0F0F 3_001D_FFFD 3_001E_FFFF 3_001F_2468
3_0020_0000

/* cpuTb.sv */
// Testbench for cpuTop: memory models, pattern loader, store and flag checks, timeout
`timescale 1ns/1ps

module cpuTb import isaPkg::*; ();

	localparam logic [wordWidth-1:0] resetAddr = '0;
	localparam int clkPeriod = 40;	// ns
	localparam int resetCycles = 16;
	localparam int maxRecords = 256;
	localparam int memWords = 256;	// Size of each memory model
	localparam int tailCycles = 8;	// Cycles watched once halted

	logic clk;
	logic rst;
	logic [wordWidth-1:0] imemAddr;
	logic [wordWidth-1:0] imemData;
	logic [wordWidth-1:0] dmemAddr;
	logic [wordWidth-1:0] dmemWrData;
	logic dmemWrite;
	logic dmemRead;
	logic [wordWidth-1:0] dmemRdData;
	logic halted;

	logic [35:0] records [maxRecords];	// Kind, address, data
	logic [wordWidth-1:0] imem [memWords];	// Indexed by word
	logic [wordWidth-1:0] dmem [memWords];
	logic [wordWidth-1:0] expAddr [$];	// Expected stores, oldest first
	logic [wordWidth-1:0] expData [$];
	int progWords;
	int storeCount;
	int cycleCount;
	int cycleLimit;
	int haltCycles;	// Cycles seen with halted high

	cpuTop #(.resetAddr(resetAddr)) cpuTop_i (
		.clk(clk), .rst(rst), .imemAddr(imemAddr), .imemData(imemData),
		.dmemAddr(dmemAddr), .dmemWrData(dmemWrData), .dmemWrite(dmemWrite),
		.dmemRead(dmemRead), .dmemRdData(dmemRdData), .halted(halted)
	);

	always #(clkPeriod/2) clk = ~clk;

	task automatic stopOnError();
		$display("Finished with errors");
		$fatal(1, "Simulation stopped after a failed check");
	endtask

	task automatic checkWord(input string name, input logic [wordWidth-1:0] actual,
		input logic [wordWidth-1:0] expected);
		if (actual !== expected)
		begin
			$display("Error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
			stopOnError();
		end
	endtask

	task automatic checkFlag(input string name, input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("Error at %0d ns: %s is %b, expected %b", $time, name, actual, expected);
			stopOnError();
		end
	endtask

	// Fill both memories, then apply the records
	task automatic loadPatterns();
		logic [3:0] kind;
		logic [wordWidth-1:0] addr;
		logic [wordWidth-1:0] data;
		for (int i = 0; i < memWords; i++)
		begin
			imem[i] = {opHalt, 4'h0, 8'(i)};	// Stray fetch halts, tagged with its slot
			dmem[i] = {~8'(i), 8'(i)};
		end
		for (int i = 0; i < maxRecords; i++)
			records[i] = '0;	// Kind 0 marks an unused slot
		$readmemh("cpuPatterns.txt", records);
		for (int i = 0; i < maxRecords; i++)
		begin
			kind = records[i][35:32];
			addr = records[i][31:16];
			data = records[i][15:0];
			if (kind != 4'h0 && addr >= memWords)
			begin
				$display("Pattern record %0d has address %h outside the memory model", i, addr);
				stopOnError();
			end
			case (kind)
				4'h1:
				begin
					imem[addr[8:1]] = data;	// Byte address to word slot
					progWords++;
				end
				4'h2: dmem[addr[7:0]] = data;
				4'h3:
				begin
					expAddr.push_back(addr);
					expData.push_back(data);
				end
				default: ;
			endcase
		end
		if (progWords == 0)
		begin
			$display("No program words were found in cpuPatterns.txt");
			stopOnError();
		end
	endtask

	// One store at the ports against the next expected one
	task automatic takeStore();
		logic [wordWidth-1:0] wantAddr;
		logic [wordWidth-1:0] wantData;
		if (expAddr.size() == 0)
		begin
			$display("Unexpected store of %h to address %h at %0d ns", dmemWrData, dmemAddr, $time);
			stopOnError();
		end
		wantAddr = expAddr.pop_front();
		wantData = expData.pop_front();
		checkWord("dmemAddr", dmemAddr, wantAddr);
		checkWord("dmemWrData", dmemWrData, wantData);
		dmem[dmemAddr[7:0]] = dmemWrData;	// Lands before any later read
		storeCount++;
	endtask

	// Combinational memories, refreshed once the DUT outputs settle
	task automatic serveMemories();
		if (imemAddr >= 2 * memWords)
		begin
			$display("Fetch from address %h lies outside the instruction memory", imemAddr);
			stopOnError();
		end
		imemData = imem[imemAddr[8:1]];
		dmemRdData = dmemRead ? dmem[dmemAddr[7:0]] : '0;
	endtask

	task automatic watchCycle();
		if (haltCycles > 0)
			checkFlag("halted", halted, 1'b1);	// Sticky once set
		if (storeCount == 0)
			checkFlag("halted", halted, 1'b0);
		if (halted)
		begin
			haltCycles++;
			checkFlag("dmemWrite", dmemWrite, 1'b0);	// Nothing stored past HLT
		end
		if ((dmemWrite || dmemRead) && dmemAddr >= memWords)
		begin
			$display("Data access at address %h lies outside the data memory", dmemAddr);
			stopOnError();
		end
		if (dmemWrite)
			takeStore();
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b0;	// In reset from time zero
		imemData = '0;
		dmemRdData = '0;
		progWords = 0;
		storeCount = 0;
		cycleCount = 0;
		haltCycles = 0;
		loadPatterns();
		cycleLimit = 8 * progWords + 40;
		repeat (resetCycles)
		begin
			@(negedge clk);
			checkFlag("dmemWrite", dmemWrite, 1'b0);
			checkFlag("dmemRead", dmemRead, 1'b0);
			checkFlag("halted", halted, 1'b0);
			checkWord("imemAddr", imemAddr, resetAddr);
			serveMemories();
		end
		rst = 1'b1;	// Released on a falling edge
		while (haltCycles < tailCycles)
		begin
			@(negedge clk);
			cycleCount++;
			if (cycleCount > cycleLimit)
			begin
				$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
				stopOnError();
			end
			watchCycle();
			serveMemories();	// After the store, so a later load sees it
		end
		if (expAddr.size() > 0)
		begin
			$display("%0d expected stores are missing after %0d seen", expAddr.size(), storeCount);
			stopOnError();
		end
		else
		begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

/* cpuTop.sv */
// Processor top level: stage instances, pipeline interfaces and memory ports
`timescale 1ns/1ps

module cpuTop import isaPkg::*; #(
	parameter logic [wordWidth-1:0] resetAddr = '0	// First fetch address
) (
	input logic clk,
	input logic rst,
	output logic [wordWidth-1:0] imemAddr,
	input logic [wordWidth-1:0] imemData,
	output logic [wordWidth-1:0] dmemAddr,
	output logic [wordWidth-1:0] dmemWrData,
	output logic dmemWrite,
	output logic dmemRead,
	input logic [wordWidth-1:0] dmemRdData,
	output logic halted
);

	idExIf idExBus ();
	exMemIf exMemBus ();
	wbIf wbBus ();

	// Fetch register outputs
	logic fetchValid;
	logic [wordWidth-1:0] fetchPc;
	instrWord fetchInstr;

	logic hold;	// Load-use stall or halt
	logic redirect;	// Taken branch
	logic [wordWidth-1:0] target;

	fetchStage #(.resetAddr(resetAddr)) fetch_i (
		.clk(clk), .rst(rst), .hold(hold), .redirect(redirect), .target(target),
		.imemAddr(imemAddr), .imemData(imemData),
		.valid(fetchValid), .pc(fetchPc), .instr(fetchInstr)
	);

	decodeStage decode_i (
		.clk(clk), .rst(rst), .valid(fetchValid), .pc(fetchPc), .instr(fetchInstr),
		.redirect(redirect), .hold(hold), .idEx(idExBus.decode), .wb(wbBus.sink)
	);

	executeStage execute_i (
		.clk(clk), .rst(rst), .idEx(idExBus.execute), .exMem(exMemBus.execute),
		.wb(wbBus.sink), .redirect(redirect), .target(target)
	);

	memStage mem_i (
		.clk(clk), .rst(rst), .exMem(exMemBus.mem),
		.dmemAddr(dmemAddr), .dmemWrData(dmemWrData), .dmemWrite(dmemWrite),
		.dmemRead(dmemRead), .dmemRdData(dmemRdData), .wb(wbBus.source), .halted(halted)
	);

endmodule

/* decodeStage.sv */
// Decode stage: control decode, immediates, hazard detection and the decode-to-execute register
`timescale 1ns/1ps

module decodeStage import isaPkg::*, corePkg::*; (
	input logic clk,
	input logic rst,
	input logic valid,
	input logic [wordWidth-1:0] pc,
	input instrWord instr,
	input logic redirect,
	output logic hold,
	idExIf.decode idEx,
	wbIf.sink wb
);

	logic [wordWidth-1:0] rdDataA;
	logic [wordWidth-1:0] rdDataB;
	logic [aluOpWidth-1:0] decAluOp;
	logic decUseImm;
	logic [wordWidth-1:0] decImm;
	logic decRegWrite;
	logic decR15Write;
	logic decMemRead;
	logic decMemWrite;
	logic [branchWidth-1:0] decBranch;
	logic haltNow;	// Valid HLT sitting here
	logic haltSeen;	// HLT already issued
	logic loadUse;
	logic bubble;

	regFile regs_i (
		.clk(clk), .rst(rst), .rdAddrA(instr.regForm.ra), .rdAddrB(instr.regForm.rb),
		.rdDataA(rdDataA), .rdDataB(rdDataB), .wb(wb)
	);

	always_comb
	begin
		decAluOp = aluAdd;
		decUseImm = 1'b0;
		decImm = '0;
		decRegWrite = 1'b0;
		decR15Write = 1'b0;
		decMemRead = 1'b0;
		decMemWrite = 1'b0;
		decBranch = brNone;
		case (instr.regForm.opcode)
			opReg:
			begin
				decRegWrite = instr.regForm.func inside {fnAdd, fnSub, fnMul, fnDiv, fnMov};
				decR15Write = instr.regForm.func inside {fnMul, fnDiv};	// Side result
				case (instr.regForm.func)
					fnSub: decAluOp = aluSub;
					fnMul: decAluOp = aluMul;
					fnDiv: decAluOp = aluDiv;
					fnMov: decAluOp = aluPassB;
					default: decAluOp = aluAdd;
				endcase
			end
			opAndi, opOri:
			begin
				decAluOp = (instr.immForm.opcode == opAndi) ? aluAnd : aluOr;
				decUseImm = 1'b1;
				decImm = {{(wordWidth-8){1'b0}}, instr.immForm.imm8};	// Zero-extended
				decRegWrite = 1'b1;
			end
			opLw, opSw:
			begin
				decUseImm = 1'b1;	// rb plus offset
				decImm = {{(wordWidth-4){instr.memForm.off4[3]}}, instr.memForm.off4};
				decMemRead = (instr.memForm.opcode == opLw);
				decMemWrite = (instr.memForm.opcode == opSw);
				decRegWrite = (instr.memForm.opcode == opLw);
			end
			opBgt, opBlt, opBeq:
			begin
				decImm = {{(wordWidth-8){instr.immForm.imm8[7]}}, instr.immForm.imm8};
				decBranch = (instr.immForm.opcode == opBgt) ? brGt :
					(instr.immForm.opcode == opBlt) ? brLt : brEq;
			end
			default: decAluOp = aluAdd;	// HLT and unknown opcodes write nothing
		endcase
	end

	// Load in execute feeding this instruction
	assign loadUse = valid && idEx.memRead &&
		(idEx.dest == instr.regForm.ra || idEx.dest == instr.regForm.rb);
	assign haltNow = valid && (instr.regForm.opcode == opHalt);
	assign hold = loadUse || haltSeen || haltNow;	// HLT itself still issues once
	assign bubble = !valid || redirect || loadUse || haltSeen;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			haltSeen <= 1'b0;
		else if (haltNow && !bubble)
			haltSeen <= 1'b1;	// Sticky, fetch never resumes
	end

	// Control half of the register, cleared for bubbles
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			idEx.valid <= 1'b0;
			idEx.regWrite <= 1'b0;
			idEx.r15Write <= 1'b0;
			idEx.memRead <= 1'b0;
			idEx.memWrite <= 1'b0;
			idEx.branchKind <= brNone;
			idEx.halt <= 1'b0;
		end
		else
		begin
			idEx.valid <= !bubble;
			idEx.regWrite <= decRegWrite && !bubble;
			idEx.r15Write <= decR15Write && !bubble;
			idEx.memRead <= decMemRead && !bubble;
			idEx.memWrite <= decMemWrite && !bubble;
			idEx.branchKind <= bubble ? brNone : decBranch;
			idEx.halt <= haltNow && !bubble;
		end
	end

	always_ff @(posedge clk)
	begin
		idEx.pc <= pc;
		idEx.aluOp <= decAluOp;
		idEx.useImm <= decUseImm;
		idEx.imm <= decImm;
		idEx.opA <= rdDataA;
		idEx.opB <= rdDataB;
		idEx.ra <= instr.regForm.ra;
		idEx.rb <= instr.regForm.rb;
		idEx.dest <= instr.regForm.ra;	// Every write targets ra
	end

endmodule

/* executeStage.sv */
// Execute stage: forwarding, branch resolution and the execute-to-memory register
`timescale 1ns/1ps

module executeStage import isaPkg::*, corePkg::*; (
	input logic clk,
	input logic rst,
	idExIf.execute idEx,
	exMemIf.execute exMem,
	wbIf.sink wb,
	output logic redirect,
	output logic [wordWidth-1:0] target
);

	logic [wordWidth-1:0] valA;	// Forwarded ra
	logic [wordWidth-1:0] valB;	// Forwarded rb
	logic [wordWidth-1:0] aluA;
	logic [wordWidth-1:0] aluB;
	logic [wordWidth-1:0] aluResult;
	logic [wordWidth-1:0] aluR15;
	logic taken;

	// Newest writer of r, R15 side writes included
	function automatic logic [fwdWidth-1:0] pickSrc(input logic [regAddrWidth-1:0] r);
		if (r == '0)
			return fwdNone;
		if ((exMem.regWrite && exMem.dest == r) || (exMem.r15Write && r == '1))
			return fwdMem;
		if ((wb.regWrite && wb.dest == r) || (wb.r15Write && r == '1))
			return fwdWb;
		return fwdNone;
	endfunction

	function automatic logic [wordWidth-1:0] fwdValue(input logic [regAddrWidth-1:0] r,
		input logic [wordWidth-1:0] regVal);
		case (pickSrc(r))
			fwdMem: return (exMem.regWrite && exMem.dest == r) ? exMem.result : exMem.r15Result;
			fwdWb: return (wb.regWrite && wb.dest == r) ? wb.data : wb.r15Data;
			default: return regVal;
		endcase
	endfunction

	always_comb
	begin
		valA = fwdValue(idEx.ra, idEx.opA);
		valB = fwdValue(idEx.rb, idEx.opB);
	end

	assign aluA = (idEx.memRead || idEx.memWrite) ? valB : valA;	// Base is rb for LW and SW
	assign aluB = idEx.useImm ? idEx.imm : valB;

	aluUnit alu_i (
		.opA(aluA), .opB(aluB), .aluOp(idEx.aluOp), .result(aluResult), .r15Result(aluR15)
	);

	// Signed compare of ra with zero
	always_comb
	begin
		case (idEx.branchKind)
			brGt: taken = $signed(valA) > 0;
			brLt: taken = $signed(valA) < 0;
			brEq: taken = valA == '0;
			default: taken = 1'b0;
		endcase
	end

	assign redirect = idEx.valid && taken;
	assign target = idEx.pc + wordWidth'(2) + {idEx.imm[wordWidth-2:0], 1'b0};

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			exMem.valid <= 1'b0;
			exMem.regWrite <= 1'b0;
			exMem.r15Write <= 1'b0;
			exMem.memRead <= 1'b0;
			exMem.memWrite <= 1'b0;
			exMem.halt <= 1'b0;
		end
		else
		begin
			exMem.valid <= idEx.valid;	// Branch itself stays valid
			exMem.regWrite <= idEx.regWrite;
			exMem.r15Write <= idEx.r15Write;
			exMem.memRead <= idEx.memRead;
			exMem.memWrite <= idEx.memWrite;
			exMem.halt <= idEx.halt;
		end
	end

	always_ff @(posedge clk)
	begin
		exMem.result <= aluResult;
		exMem.r15Result <= aluR15;
		exMem.storeData <= valA;	// SW stores ra
		exMem.dest <= idEx.dest;
	end

endmodule

/* fetchStage.sv */
// Fetch stage: program counter and fetch-to-decode register
`timescale 1ns/1ps

module fetchStage import isaPkg::*; #(
	parameter logic [wordWidth-1:0] resetAddr = '0
) (
	input logic clk,
	input logic rst,
	input logic hold,
	input logic redirect,
	input logic [wordWidth-1:0] target,
	output logic [wordWidth-1:0] imemAddr,
	input instrWord imemData,
	output logic valid,
	output logic [wordWidth-1:0] pc,
	output instrWord instr
);

	logic [wordWidth-1:0] pcReg;

	assign imemAddr = pcReg;	// Memory answers in the same cycle

	// Redirect beats hold
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			pcReg <= resetAddr;
			valid <= 1'b0;
		end
		else if (redirect)
		begin
			pcReg <= target;
			valid <= 1'b0;	// Flush the wrong-path word
		end
		else if (!hold)
		begin
			pcReg <= pcReg + wordWidth'(2);
			valid <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!hold)
		begin
			pc <= pcReg;
			instr <= imemData;
		end
	end

endmodule

/* flist.f */
isaPkg.sv
corePkg.sv
stageIfs.sv
aluUnit.sv
regFile.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memStage.sv
cpuTop.sv
cpuTb.sv

/* isaPkg.sv */
// Instruction set package: word sizes, opcodes, function codes and the instruction word union
package isaPkg;

	localparam int wordWidth = 16;	// Data, address and instruction width
	localparam int regAddrWidth = 4;	// Sixteen registers

	// Opcodes, top nibble of every word
	localparam logic [3:0] opHalt = 4'h0;
	localparam logic [3:0] opBgt = 4'h4;
	localparam logic [3:0] opBlt = 4'h5;
	localparam logic [3:0] opBeq = 4'h6;
	localparam logic [3:0] opAndi = 4'h8;
	localparam logic [3:0] opOri = 4'h9;
	localparam logic [3:0] opLw = 4'hC;
	localparam logic [3:0] opSw = 4'hD;
	localparam logic [3:0] opReg = 4'hF;	// Register form, function in low nibble

	// Function codes of the register form
	localparam logic [3:0] fnAdd = 4'h0;
	localparam logic [3:0] fnSub = 4'h1;
	localparam logic [3:0] fnMul = 4'h4;	// Low half to ra, high half to R15
	localparam logic [3:0] fnDiv = 4'h5;	// Quotient to ra, remainder to R15
	localparam logic [3:0] fnMov = 4'h7;

	// Same sixteen bits seen three ways
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [regAddrWidth-1:0] ra;
			logic [regAddrWidth-1:0] rb;
			logic [3:0] func;
		} regForm;
		struct packed {
			logic [3:0] opcode;
			logic [regAddrWidth-1:0] ra;
			logic [7:0] imm8;	// Logic immediate or branch offset
		} immForm;
		struct packed {
			logic [3:0] opcode;
			logic [regAddrWidth-1:0] ra;
			logic [regAddrWidth-1:0] rb;	// Base register
			logic [3:0] off4;	// Signed offset
		} memForm;
	} instrWord;

endpackage

/* memStage.sv */
// Memory stage: data memory access, memory-to-writeback register and halted flag
`timescale 1ns/1ps

module memStage import isaPkg::*; (
	input logic clk,
	input logic rst,
	exMemIf.mem exMem,
	output logic [wordWidth-1:0] dmemAddr,
	output logic [wordWidth-1:0] dmemWrData,
	output logic dmemWrite,
	output logic dmemRead,
	input logic [wordWidth-1:0] dmemRdData,
	wbIf.source wb,
	output logic halted
);

	assign dmemAddr = exMem.result;
	assign dmemWrData = exMem.storeData;
	assign dmemWrite = exMem.valid && exMem.memWrite;	// Written at the clock edge
	assign dmemRead = exMem.valid && exMem.memRead;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			wb.regWrite <= 1'b0;
			wb.r15Write <= 1'b0;
			halted <= 1'b0;
		end
		else
		begin
			wb.regWrite <= exMem.valid && exMem.regWrite;
			wb.r15Write <= exMem.valid && exMem.r15Write;
			if (exMem.valid && exMem.halt)
				halted <= 1'b1;	// Stays set until reset
		end
	end

	always_ff @(posedge clk)
	begin
		wb.dest <= exMem.dest;
		wb.data <= exMem.memRead ? dmemRdData : exMem.result;	// Load data or ALU result
		wb.r15Data <= exMem.r15Result;
	end

endmodule

/* regFile.sv */
// Register file: sixteen registers, write-through reads, extra R15 write port
`timescale 1ns/1ps

module regFile import isaPkg::*; (
	input logic clk,
	input logic rst,
	input logic [regAddrWidth-1:0] rdAddrA,
	input logic [regAddrWidth-1:0] rdAddrB,
	output logic [wordWidth-1:0] rdDataA,
	output logic [wordWidth-1:0] rdDataB,
	wbIf.sink wb
);

	logic [wordWidth-1:0] regs [2**regAddrWidth];

	// Bypass the write landing this cycle, ra port first
	function automatic logic [wordWidth-1:0] readPort(input logic [regAddrWidth-1:0] addr);
		if (addr == '0)
			return '0;	// R0 hardwired
		if (wb.regWrite && wb.dest == addr)
			return wb.data;
		if (wb.r15Write && addr == '1)
			return wb.r15Data;
		return regs[addr];
	endfunction

	always_comb
	begin
		rdDataA = readPort(rdAddrA);
		rdDataB = readPort(rdAddrB);
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 0; i < 2**regAddrWidth; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (wb.r15Write)
				regs[2**regAddrWidth-1] <= wb.r15Data;
			if (wb.regWrite && wb.dest != '0)
				regs[wb.dest] <= wb.data;	// Later write, so ra wins on R15
		end
	end

endmodule

/* stageIfs.sv */
// Pipeline register interfaces idExIf, exMemIf and wbIf
`timescale 1ns/1ps

// Decode to execute register contents
interface idExIf import isaPkg::*, corePkg::*; ();
	logic valid;
	logic [wordWidth-1:0] pc;	// Branch base
	logic [aluOpWidth-1:0] aluOp;
	logic useImm;	// ALU B input from imm
	logic [wordWidth-1:0] imm;
	logic [wordWidth-1:0] opA;	// Register value of ra
	logic [wordWidth-1:0] opB;	// Register value of rb
	logic [regAddrWidth-1:0] ra;
	logic [regAddrWidth-1:0] rb;
	logic [regAddrWidth-1:0] dest;
	logic regWrite;
	logic r15Write;
	logic memRead;
	logic memWrite;
	logic [branchWidth-1:0] branchKind;
	logic halt;

	modport decode (output valid, pc, aluOp, useImm, imm, opA, opB, ra, rb, dest,
		regWrite, r15Write, memRead, memWrite, branchKind, halt);
	modport execute (input valid, pc, aluOp, useImm, imm, opA, opB, ra, rb, dest,
		regWrite, r15Write, memRead, memWrite, branchKind, halt);
endinterface

// Execute to memory register contents
interface exMemIf import isaPkg::*; ();
	logic valid;
	logic [wordWidth-1:0] result;	// ALU result or memory address
	logic [wordWidth-1:0] r15Result;	// Product high half or remainder
	logic [wordWidth-1:0] storeData;
	logic [regAddrWidth-1:0] dest;
	logic regWrite;
	logic r15Write;
	logic memRead;
	logic memWrite;
	logic halt;

	modport execute (output valid, result, r15Result, storeData, dest, regWrite, r15Write,
		memRead, memWrite, halt);
	modport mem (input valid, result, r15Result, storeData, dest, regWrite, r15Write,
		memRead, memWrite, halt);
endinterface

// Write-back register contents, both write ports
interface wbIf import isaPkg::*; ();
	logic regWrite;
	logic [regAddrWidth-1:0] dest;
	logic [wordWidth-1:0] data;
	logic r15Write;
	logic [wordWidth-1:0] r15Data;

	modport source (output regWrite, dest, data, r15Write, r15Data);
	modport sink (input regWrite, dest, data, r15Write, r15Data);
endinterface
